// File: Makefile
VERILATOR ?= verilator
FLIST     ?= dbg_mem_top.f
TOP       ?= dbg_mem_top_tb
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR FLIST TOP BUILD VFLAGS"

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

test: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(BUILD)

// File: dbg_mem_top.f
hdl/dbg_map_pkg.sv
hdl/dbg_ctrl_pkg.sv
hdl/dbg_bus_decode.sv
hdl/dbg_hart_status.sv
hdl/dbg_cmd_fsm.sv
hdl/dbg_read_mux.sv
hdl/dbg_mem_top.sv
dv/dbg_mem_top_assert.sv
dv/dbg_mem_top_tb.sv

// File: dv/dbg_mem_top_assert.sv
/* concurrent checks on the debug memory top level, bound into
   every instance of it */
module dbg_mem_top_assert #(
  parameter int unsigned        NrHarts         = 4,
  parameter logic [NrHarts-1:0] SelectableHarts = {NrHarts{1'b1}}
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  cmdbusy_o,
  input logic [NrHarts-1:0]    halted_o,
  input logic                  data_valid_o,
  input dbg_map_pkg::bus_req_t bus_i
);

  // sequencer leaves reset idle
  busy_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !cmdbusy_o)
    else $error("cmdbusy_o high right after reset");

  // ----------------------------------------------------------
  // hart flags
  // ----------------------------------------------------------
  unselectable_halted: assert property (@(posedge clk_i)
      disable iff (!rst_ni) (halted_o & ~SelectableHarts) == '0)
    else $error("halted_o set for an unselectable hart");

  // data updates only come from hart writes
  data_valid_write: assert property (@(posedge clk_i)
      disable iff (!rst_ni) data_valid_o |-> (bus_i.req && bus_i.we))
    else $error("data_valid_o without a write request");

endmodule

bind dbg_mem_top dbg_mem_top_assert #(
  .NrHarts(NrHarts),
  .SelectableHarts(SelectableHarts)
) i_dbg_mem_top_assert (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .cmdbusy_o(cmdbusy_o),
  .halted_o(halted_o),
  .data_valid_o(data_valid_o),
  .bus_i(bus_i)
);

// File: dv/dbg_mem_top_tb.sv
/* testbench for the debug memory top level: a table of hart accesses and
   debugger levels, applied one row per cycle and checked mid-cycle */
module dbg_mem_top_tb;

  localparam int unsigned NrHarts = 4;
  localparam int unsigned ResetCycles = 10;

  // jal x0 words from the RISC-V J-type layout, offsets taken from the address map
  // whereto 0x300 to resume 0x808, offset +0x508
  localparam dbg_map_pkg::word_t JumpToResume = 32'h5080_006F;
  // whereto 0x300 to the command area 0x338, offset +0x038
  localparam dbg_map_pkg::word_t JumpToCmd    = 32'h0380_006F;

  // one cycle of stimulus and the outputs seen in that cycle
  typedef struct packed {
    dbg_map_pkg::bus_req_t                           bus;
    dbg_map_pkg::hartsel_t                           hartsel;
    logic [NrHarts-1:0]                              haltreq;
    logic [NrHarts-1:0]                              resumereq;
    logic                                            clr;
    logic                                            cmd_valid;
    dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] data;
    logic [NrHarts-1:0]                              exp_halted;
    logic [NrHarts-1:0]                              exp_resuming;
    logic                                            exp_busy;
    logic                                            exp_err_valid;
    dbg_ctrl_pkg::cmderr_e                           exp_err;
    logic                                            exp_data_valid;
    dbg_map_pkg::word_t                              exp_rdata;
  } row_t;

  logic                                            clk_i;
  logic                                            rst_ni;
  dbg_map_pkg::hartsel_t                           hartsel_i;
  logic [NrHarts-1:0]                              haltreq_i, resumereq_i;
  logic                                            clear_resumeack_i, cmd_valid_i;
  dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] data_i, data_o;
  dbg_map_pkg::bus_req_t                           bus_i;
  logic [NrHarts-1:0]                              debug_req_o, halted_o, resuming_o;
  logic                                            data_valid_o, cmderror_valid_o, cmdbusy_o;
  dbg_ctrl_pkg::cmderr_e                           cmderror_o;
  dbg_map_pkg::word_t                              rdata_o;

  row_t rows[$];
  row_t cur;
  dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] data_words;
  int unsigned n_word, n_bits, n_err, n_bit;
  int unsigned row_idx;
  logic rows_ready;

  dbg_mem_top #(.NrHarts(NrHarts), .SelectableHarts(4'b0111)) i_dbg_mem_top (
    .clk_i, .rst_ni, .hartsel_i, .haltreq_i, .resumereq_i, .clear_resumeack_i,
    .cmd_valid_i, .data_i, .bus_i, .debug_req_o, .halted_o, .resuming_o, .data_o,
    .data_valid_o, .cmderror_valid_o, .cmderror_o, .cmdbusy_o, .rdata_o
  );

  always #5 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic check_word(string name, dbg_map_pkg::word_t got, dbg_map_pkg::word_t exp);
    if (got !== exp) begin
      n_word++;
      $display("ERROR row %0d %s: got 0x%h expected 0x%h", row_idx, name, got, exp);
    end
  endtask

  task automatic check_bits(string name, logic [NrHarts-1:0] got, logic [NrHarts-1:0] exp);
    if (got !== exp) begin
      n_bits++;
      $display("ERROR row %0d %s: got 0x%h expected 0x%h", row_idx, name, got, exp);
    end
  endtask

  task automatic check_err(string name, dbg_ctrl_pkg::cmderr_e got,
                           dbg_ctrl_pkg::cmderr_e exp);
    if (got !== exp) begin
      n_err++;
      $display("ERROR row %0d %s: got 0x%h expected 0x%h", row_idx, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      n_bit++;
      $display("ERROR row %0d %s: got 0x%h expected 0x%h", row_idx, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // table building
  // ----------------------------------------------------------
  function automatic dbg_map_pkg::bus_req_t acc(logic we, dbg_map_pkg::addr_t a,
                                                dbg_map_pkg::word_t d, dbg_map_pkg::be_t be);
    dbg_map_pkg::bus_req_t b;
    b.req   = 1'b1;
    b.we    = we;
    b.addr  = dbg_map_pkg::word_t'(a);
    b.wdata = d;
    b.be    = be;
    return b;
  endfunction

  // enabled byte lanes of the write replace the addressed data word
  function automatic dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] merge_data(
      dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] base, dbg_map_pkg::bus_req_t b);
    int unsigned        idx;
    dbg_map_pkg::word_t mask;
    idx  = (b.addr[11:0] - dbg_map_pkg::DataAddr) / 4;
    mask = {{8{b.be[3]}}, {8{b.be[2]}}, {8{b.be[1]}}, {8{b.be[0]}}};
    base[idx] = (base[idx] & ~mask) | (b.wdata & mask);
    return base;
  endfunction

  // push one row and drop the one-shot fields back to idle
  task automatic push(dbg_map_pkg::bus_req_t b);
    cur.bus = b;
    rows.push_back(cur);
    cur.clr            = 1'b0;
    cur.cmd_valid      = 1'b0;
    cur.exp_err_valid  = 1'b0;
    cur.exp_err        = dbg_ctrl_pkg::CmdErrNone;
    cur.exp_data_valid = 1'b0;
  endtask

  task automatic build_rows();
    dbg_map_pkg::bus_req_t idle;
    idle = '0;
    cur  = '0;
    cur.data = data_words;
    // halted writes for harts 0, 1 and 3 where hart 3 is not selectable
    push(acc(1'b1, dbg_map_pkg::HaltedAddr, 32'd0, 4'hF));
    cur.exp_halted = 4'b0001;
    cur.haltreq = 4'b0010;
    push(acc(1'b1, dbg_map_pkg::HaltedAddr, 32'd1, 4'hF));
    cur.exp_halted = 4'b0011;
    cur.haltreq = 4'b0000;
    push(acc(1'b1, dbg_map_pkg::HaltedAddr, 32'd3, 4'hF));
    push(idle);
    // resume of hart 1
    cur.hartsel   = 20'd1;
    cur.resumereq = 4'b0010;
    push(idle);
    cur.exp_busy = 1'b1;
    push(acc(1'b0, dbg_map_pkg::FlagsBaseAddr, 32'd0, 4'hF));
    cur.exp_rdata = 32'h0000_0200;
    push(acc(1'b1, dbg_map_pkg::ResumingAddr, 32'd1, 4'hF));
    cur.exp_halted   = 4'b0001;
    cur.exp_resuming = 4'b0010;
    push(idle);
    cur.exp_busy = 1'b0;
    push(acc(1'b0, dbg_map_pkg::WhereToAddr, 32'd0, 4'hF));
    cur.exp_rdata = JumpToResume;
    cur.clr       = 1'b1;
    cur.resumereq = 4'b0000;
    push(idle);
    cur.exp_resuming = 4'b0000;
    // command on hart 0
    cur.hartsel = 20'd0;
    push(idle);
    cur.cmd_valid = 1'b1;
    push(idle);
    cur.exp_busy = 1'b1;
    push(acc(1'b0, dbg_map_pkg::FlagsBaseAddr, 32'd0, 4'hF));
    cur.exp_rdata = 32'h0000_0001;
    push(acc(1'b0, dbg_map_pkg::WhereToAddr, 32'd0, 4'hF));
    cur.exp_rdata = JumpToCmd;
    push(acc(1'b1, dbg_map_pkg::GoingAddr, 32'd0, 4'hF));
    push(acc(1'b1, dbg_map_pkg::HaltedAddr, 32'd0, 4'hF));
    cur.exp_busy = 1'b0;
    push(idle);
    // command errors
    cur.hartsel       = 20'd2;
    cur.cmd_valid     = 1'b1;
    cur.exp_err_valid = 1'b1;
    cur.exp_err       = dbg_ctrl_pkg::CmdErrHaltResume;
    push(idle);
    cur.hartsel       = 20'd0;
    cur.exp_err_valid = 1'b1;
    cur.exp_err       = dbg_ctrl_pkg::CmdErrException;
    push(acc(1'b1, dbg_map_pkg::ExceptionAddr, 32'd0, 4'hF));
    // data register merge and read back
    cur.exp_data_valid = 1'b1;
    push(acc(1'b1, dbg_map_pkg::DataAddr + 12'h4, 32'hA5A5_5A5A, 4'b0101));
    push(acc(1'b0, dbg_map_pkg::DataAddr + 12'h4, 32'd0, 4'hF));
    cur.exp_rdata = data_words[1];
    push(idle);
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin : main
    row_t r;
    dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] exp_data;
    rows_ready = 1'b0;
    clk_i = 1'b0;
    rst_ni <= 1'b0;
    hartsel_i <= '0;
    haltreq_i <= '0;
    resumereq_i <= '0;
    clear_resumeack_i <= 1'b0;
    cmd_valid_i <= 1'b0;
    data_i <= '0;
    bus_i <= '0;
    void'($urandom(23));
    data_words[0] = $urandom;
    data_words[1] = $urandom;
    build_rows();
    rows_ready = 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int unsigned i = 0; i < rows.size(); i++) begin
      r = rows[i];
      @(posedge clk_i);
      bus_i             <= r.bus;
      hartsel_i         <= r.hartsel;
      haltreq_i         <= r.haltreq;
      resumereq_i       <= r.resumereq;
      clear_resumeack_i <= r.clr;
      cmd_valid_i       <= r.cmd_valid;
      data_i            <= r.data;
      // mid-cycle sample where comb outputs have settled
      @(negedge clk_i);
      row_idx  = i;
      exp_data = r.exp_data_valid ? merge_data(r.data, r.bus) : r.data;
      check_bits("debug_req_o", debug_req_o, r.haltreq);
      check_bits("halted_o", halted_o, r.exp_halted);
      check_bits("resuming_o", resuming_o, r.exp_resuming);
      check_bit("cmdbusy_o", cmdbusy_o, r.exp_busy);
      check_bit("cmderror_valid_o", cmderror_valid_o, r.exp_err_valid);
      check_err("cmderror_o", cmderror_o, r.exp_err);
      check_bit("data_valid_o", data_valid_o, r.exp_data_valid);
      check_word("data_o[0]", data_o[0], exp_data[0]);
      check_word("data_o[1]", data_o[1], exp_data[1]);
      check_word("rdata_o", rdata_o, r.exp_rdata);
    end
    $display("errors: word %0d bits %0d cmderr %0d bit %0d", n_word, n_bits, n_err, n_bit);
    if (n_word + n_bits + n_err + n_bit == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // four cycles of slack per row on top of reset
  initial begin : watchdog
    wait (rows_ready === 1'b1);
    #(rows.size() * 10 * 4 + ResetCycles * 10);
    $display("timeout: the stimulus table did not finish in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: hdl/dbg_bus_decode.sv
/* write side of the debug memory: turns hart writes into flag strobes,
   going and exception pulses, and byte-merged data register updates */
module dbg_bus_decode #(
  parameter int unsigned  NrHarts    = 4,
  localparam int unsigned HartSelLen = (NrHarts == 1) ? 1 : $clog2(NrHarts)
) (
  input  dbg_map_pkg::bus_req_t                            bus_i,
  input  logic [HartSelLen-1:0]                            hart_sel_i,
  input  logic                                             clear_resumeack_i,
  input  dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0]  data_i,
  output dbg_ctrl_pkg::hart_strobe_t [NrHarts-1:0]         strobe_o,
  output logic                                             going_o,
  output logic                                             exception_o,
  output dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0]  data_o,
  output logic                                             data_valid_o
);

  localparam int unsigned DataIdxLen =
      (dbg_map_pkg::DataCount > 1) ? $clog2(dbg_map_pkg::DataCount) : 1;
  // last byte of the data area
  localparam dbg_map_pkg::addr_t DataEndAddr =
      dbg_map_pkg::addr_t'(dbg_map_pkg::DataAddr + 4 * dbg_map_pkg::DataCount - 1);

  logic                  write;
  dbg_map_pkg::addr_t    addr;
  logic [HartSelLen-1:0] wdata_hart;
  logic [DataIdxLen-1:0] data_idx;
  logic                  data_hit;

  assign write      = bus_i.req & bus_i.we;
  // upper address bits select the debug module, not decoded here
  assign addr       = bus_i.addr[11:0];
  // hart names itself in the low bits of the written word
  assign wdata_hart = bus_i.wdata[HartSelLen-1:0];
  assign data_idx   = DataIdxLen'((addr - dbg_map_pkg::DataAddr) >> 2);
  assign data_hit   = (addr >= dbg_map_pkg::DataAddr) && (addr <= DataEndAddr);

  // ----------------------------------------------------------
  // per-hart strobes
  // ----------------------------------------------------------
  always_comb begin : p_strobes
    for (int unsigned h = 0; h < NrHarts; h++) begin
      strobe_o[h].halted_set   = write && (addr == dbg_map_pkg::HaltedAddr) &&
                                 (wdata_hart == HartSelLen'(h));
      strobe_o[h].resuming_set = write && (addr == dbg_map_pkg::ResumingAddr) &&
                                 (wdata_hart == HartSelLen'(h));
      // ack clear always targets the debugger's selected hart
      strobe_o[h].resume_clr   = clear_resumeack_i && (hart_sel_i == HartSelLen'(h));
    end
  end

  // hart has picked up the command
  assign going_o     = write && (addr == dbg_map_pkg::GoingAddr);
  // command trapped while executing
  assign exception_o = write && (addr == dbg_map_pkg::ExceptionAddr);

  // ----------------------------------------------------------
  // data registers
  // ----------------------------------------------------------
  always_comb begin : p_data
    data_o       = data_i;
    data_valid_o = 1'b0;
    if (write && data_hit) begin
      data_valid_o = 1'b1;
      // only enabled lanes take the hart's bytes
      for (int unsigned b = 0; b < $bits(dbg_map_pkg::be_t); b++) begin
        if (bus_i.be[b]) begin
          data_o[data_idx][b*8 +: 8] = bus_i.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: hdl/dbg_cmd_fsm.sv
/* sequences abstract commands and resume requests for the selected hart,
   drives the go and resume flags, busy and command errors */
module dbg_cmd_fsm #(
  parameter int unsigned  NrHarts    = 4,
  localparam int unsigned HartSelLen = (NrHarts == 1) ? 1 : $clog2(NrHarts)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [HartSelLen-1:0] hart_sel_i,
  input  logic                  cmd_valid_i,
  input  logic [NrHarts-1:0]    haltreq_i,
  input  logic [NrHarts-1:0]    resumereq_i,
  input  logic [NrHarts-1:0]    halted_i,
  input  logic [NrHarts-1:0]    resuming_i,
  input  logic [NrHarts-1:0]    halted_set_i,
  input  logic                  going_i,
  input  logic                  exception_i,
  output logic                  go_o,
  output logic                  resume_o,
  output logic                  cmdbusy_o,
  output logic                  cmderror_valid_o,
  output dbg_ctrl_pkg::cmderr_e cmderror_o
);

  // widen to a power of two so any select value indexes in range
  localparam int unsigned NrAligned = 2 ** HartSelLen;

  logic [NrAligned-1:0] haltreq_al, resumereq_al, halted_al, resuming_al, halted_set_al;

  dbg_ctrl_pkg::cmd_state_e state_d, state_q;

  assign haltreq_al    = NrAligned'(haltreq_i);
  assign resumereq_al  = NrAligned'(resumereq_i);
  assign halted_al     = NrAligned'(halted_i);
  assign resuming_al   = NrAligned'(resuming_i);
  assign halted_set_al = NrAligned'(halted_set_i);

  always_comb begin : p_next
    state_d          = state_q;
    cmderror_valid_o = 1'b0;
    cmderror_o       = dbg_ctrl_pkg::CmdErrNone;
    unique case (state_q)
      dbg_ctrl_pkg::CmdIdle: begin
        if (cmd_valid_i && halted_al[hart_sel_i]) begin
          state_d = dbg_ctrl_pkg::CmdGo;
        end else if (cmd_valid_i) begin
          // commands need a halted hart
          cmderror_valid_o = 1'b1;
          cmderror_o       = dbg_ctrl_pkg::CmdErrHaltResume;
        end
        // ignored while a halt is pending or the last resume is unacked
        if (resumereq_al[hart_sel_i] && !resuming_al[hart_sel_i] &&
            !haltreq_al[hart_sel_i] && halted_al[hart_sel_i]) begin
          state_d = dbg_ctrl_pkg::CmdResume;
        end
      end
      // hart fetches whereto and jumps into the command
      dbg_ctrl_pkg::CmdGo: begin
        if (going_i) begin
          state_d = dbg_ctrl_pkg::CmdExecuting;
        end
      end
      // done once the hart parks itself again
      dbg_ctrl_pkg::CmdExecuting: begin
        if (halted_set_al[hart_sel_i]) begin
          state_d = dbg_ctrl_pkg::CmdIdle;
        end
      end
      dbg_ctrl_pkg::CmdResume: begin
        if (resuming_al[hart_sel_i]) begin
          state_d = dbg_ctrl_pkg::CmdIdle;
        end
      end
      default: state_d = dbg_ctrl_pkg::CmdIdle;
    endcase
    // a trap reported by the hart wins over everything
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_ctrl_pkg::CmdErrException;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= dbg_ctrl_pkg::CmdIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign go_o      = (state_q == dbg_ctrl_pkg::CmdGo);
  assign resume_o  = (state_q == dbg_ctrl_pkg::CmdResume);
  assign cmdbusy_o = (state_q != dbg_ctrl_pkg::CmdIdle);

endmodule

// File: hdl/dbg_ctrl_pkg.sv
/* control types of the debug memory: per-hart update strobes,
   command sequencer states and the error codes it reports */
package dbg_ctrl_pkg;

  // ----------------------------------------------------------
  // per-hart flag updates
  // ----------------------------------------------------------
  typedef struct packed {
    // hart wrote its index to the halted address
    logic halted_set;
    // hart wrote its index to the resuming address
    logic resuming_set;
    // debugger acknowledged the resume
    logic resume_clr;
  } hart_strobe_t;

  // ----------------------------------------------------------
  // command sequencer
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    CmdIdle      = 2'd0,
    CmdGo        = 2'd1,
    CmdResume    = 2'd2,
    CmdExecuting = 2'd3
  } cmd_state_e;

  // encodings follow the abstractcs cmderr field
  typedef enum logic [2:0] {
    CmdErrNone       = 3'd0,
    CmdErrException  = 3'd3,
    CmdErrHaltResume = 3'd4
  } cmderr_e;

endpackage

// File: hdl/dbg_hart_status.sv
/* halted and resuming flags of one hart, updated by its strobes;
   an unselectable hart keeps both flags at zero */
module dbg_hart_status #(
  parameter bit Selectable = 1'b1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  dbg_ctrl_pkg::hart_strobe_t strobe_i,
  output logic                       halted_o,
  output logic                       resuming_o
);

  logic halted_d, halted_q;
  logic resuming_d, resuming_q;

  always_comb begin : p_next
    halted_d   = halted_q;
    resuming_d = resuming_q;
    // debugger ack, loses against a new resuming write below
    if (strobe_i.resume_clr) begin
      resuming_d = 1'b0;
    end
    if (strobe_i.halted_set) begin
      halted_d = 1'b1;
    end
    // hart left the park loop, no longer halted
    if (strobe_i.resuming_set) begin
      halted_d   = 1'b0;
      resuming_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      halted_q   <= 1'b0;
      resuming_q <= 1'b0;
    end else begin
      halted_q   <= Selectable & halted_d;
      resuming_q <= Selectable & resuming_d;
    end
  end

  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

endmodule

// File: hdl/dbg_map_pkg.sv
/* address map, bus types and jump encoding of the debug memory
   shared by every block that decodes or answers a hart access */
package dbg_map_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  // the debug memory decodes a 12-bit window
  typedef logic [11:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;
  // hart select field as written by the debugger
  typedef logic [19:0] hartsel_t;

  // data registers visible to the hart
  localparam int unsigned DataCount = 2;

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------
  // hart reports its state by writing its index to these
  localparam addr_t HaltedAddr      = 12'h100;
  localparam addr_t GoingAddr       = 12'h104;
  localparam addr_t ResumingAddr    = 12'h108;
  localparam addr_t ExceptionAddr   = 12'h10C;
  // variable jump fetched by the parked hart
  localparam addr_t WhereToAddr     = 12'h300;
  localparam addr_t AbstractCmdAddr = 12'h338;
  localparam addr_t DataAddr        = 12'h380;
  // only the low 12 bits take part in the jump offset
  localparam word_t ResumeAddr      = 32'h0000_0808;
  // one byte of go/resume flags per hart
  localparam addr_t FlagsBaseAddr   = 12'h400;
  localparam addr_t FlagsEndAddr    = 12'h7FF;

  // plain memory request, completes in its cycle
  typedef struct packed {
    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
    be_t   be;
  } bus_req_t;

  // jal x0 with a signed 21-bit byte offset, J-type bit scatter
  function automatic word_t jal_zero(logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

endpackage

// File: hdl/dbg_mem_top.sv
/* memory-mapped side of the execution-based debug module, one flag
   tracker per hart around a shared decoder, sequencer and read mux */
module dbg_mem_top #(
  parameter int unsigned        NrHarts         = 4,
  parameter logic [NrHarts-1:0] SelectableHarts = {NrHarts{1'b1}}
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  dbg_map_pkg::hartsel_t                           hartsel_i,
  input  logic [NrHarts-1:0]                              haltreq_i,
  input  logic [NrHarts-1:0]                              resumereq_i,
  input  logic                                            clear_resumeack_i,
  input  logic                                            cmd_valid_i,
  input  dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] data_i,
  input  dbg_map_pkg::bus_req_t                           bus_i,
  output logic [NrHarts-1:0]                              debug_req_o,
  output logic [NrHarts-1:0]                              halted_o,
  output logic [NrHarts-1:0]                              resuming_o,
  output dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] data_o,
  output logic                                            data_valid_o,
  output logic                                            cmderror_valid_o,
  output dbg_ctrl_pkg::cmderr_e                           cmderror_o,
  output logic                                            cmdbusy_o,
  output dbg_map_pkg::word_t                              rdata_o
);

  localparam int unsigned HartSelLen = (NrHarts == 1) ? 1 : $clog2(NrHarts);

  logic [HartSelLen-1:0]                    hart_sel;
  dbg_ctrl_pkg::hart_strobe_t [NrHarts-1:0] strobe;
  logic [NrHarts-1:0]                       halted_set;
  logic                                     going, exception, go, resume;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;
  assign hart_sel    = hartsel_i[HartSelLen-1:0];

  dbg_bus_decode #(.NrHarts(NrHarts)) i_bus_decode (
    .bus_i, .hart_sel_i(hart_sel), .clear_resumeack_i, .data_i,
    .strobe_o(strobe), .going_o(going), .exception_o(exception),
    .data_o, .data_valid_o
  );

  // ----------------------------------------------------------
  // one flag tracker per hart
  // ----------------------------------------------------------
  for (genvar h = 0; h < NrHarts; h++) begin : gen_hart
    assign halted_set[h] = strobe[h].halted_set;
    dbg_hart_status #(.Selectable(SelectableHarts[h])) i_hart_status (
      .clk_i, .rst_ni, .strobe_i(strobe[h]),
      .halted_o(halted_o[h]), .resuming_o(resuming_o[h])
    );
  end

  dbg_cmd_fsm #(.NrHarts(NrHarts)) i_cmd_fsm (
    .clk_i, .rst_ni, .hart_sel_i(hart_sel), .cmd_valid_i, .haltreq_i, .resumereq_i,
    .halted_i(halted_o), .resuming_i(resuming_o), .halted_set_i(halted_set),
    .going_i(going), .exception_i(exception), .go_o(go), .resume_o(resume),
    .cmdbusy_o, .cmderror_valid_o, .cmderror_o
  );

  dbg_read_mux #(.NrHarts(NrHarts)) i_read_mux (
    .clk_i, .rst_ni, .bus_i, .hart_sel_i(hart_sel), .resumereq_i,
    .go_i(go), .resume_i(resume), .cmdbusy_i(cmdbusy_o), .data_i, .rdata_o
  );

endmodule

// File: hdl/dbg_read_mux.sv
/* read side of the debug memory: whereto jump, polled hart flags and
   data registers, answered one cycle after the request */
module dbg_read_mux #(
  parameter int unsigned  NrHarts    = 4,
  localparam int unsigned HartSelLen = (NrHarts == 1) ? 1 : $clog2(NrHarts)
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  dbg_map_pkg::bus_req_t                           bus_i,
  input  logic [HartSelLen-1:0]                           hart_sel_i,
  input  logic [NrHarts-1:0]                              resumereq_i,
  input  logic                                            go_i,
  input  logic                                            resume_i,
  input  logic                                            cmdbusy_i,
  input  dbg_map_pkg::word_t [dbg_map_pkg::DataCount-1:0] data_i,
  output dbg_map_pkg::word_t                              rdata_o
);

  localparam int unsigned NrAligned  = 2 ** HartSelLen;
  localparam int unsigned DataIdxLen =
      (dbg_map_pkg::DataCount > 1) ? $clog2(dbg_map_pkg::DataCount) : 1;
  localparam dbg_map_pkg::addr_t DataEndAddr =
      dbg_map_pkg::addr_t'(dbg_map_pkg::DataAddr + 4 * dbg_map_pkg::DataCount - 1);

  dbg_map_pkg::addr_t    addr;
  dbg_map_pkg::addr_t    flag_off;
  logic [NrAligned-1:0]  resumereq_al;
  logic [DataIdxLen-1:0] data_idx;
  logic [3:0][7:0]       flags;
  dbg_map_pkg::word_t    rdata_d, rdata_q;

  assign addr         = bus_i.addr[11:0];
  assign resumereq_al = NrAligned'(resumereq_i);
  assign data_idx     = DataIdxLen'((addr - dbg_map_pkg::DataAddr) >> 2);
  // word offset into the flag area, four harts per word
  assign flag_off     = (addr - dbg_map_pkg::FlagsBaseAddr) & ~dbg_map_pkg::addr_t'(3);

  always_comb begin : p_read
    rdata_d = rdata_q;
    flags   = '0;
    if (bus_i.req && !bus_i.we) begin
      // unmapped reads return zero
      rdata_d = '0;
      if (addr == dbg_map_pkg::WhereToAddr) begin
        // a pending command has priority over a resume
        if (cmdbusy_i) begin
          rdata_d = dbg_map_pkg::jal_zero(21'(dbg_map_pkg::AbstractCmdAddr) -
                                          21'(dbg_map_pkg::WhereToAddr));
        end else if (resumereq_al[hart_sel_i]) begin
          rdata_d = dbg_map_pkg::jal_zero(21'(dbg_map_pkg::ResumeAddr[11:0]) -
                                          21'(dbg_map_pkg::WhereToAddr));
        end
      end else if ((addr >= dbg_map_pkg::FlagsBaseAddr) &&
                   (addr <= dbg_map_pkg::FlagsEndAddr)) begin
        // only the selected hart sees its flags, in its own byte lane
        if (flag_off == (dbg_map_pkg::addr_t'(hart_sel_i) & ~dbg_map_pkg::addr_t'(3))) begin
          flags[2'(hart_sel_i)] = {6'b0, resume_i, go_i};
        end
        rdata_d = flags;
      end else if ((addr >= dbg_map_pkg::DataAddr) && (addr <= DataEndAddr)) begin
        rdata_d = data_i[data_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rdata
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule
